// File: source/ecc_110_pkg.sv
`default_nettype none

package ecc_110_pkg;

    // **************************************************
    // code dimensions
    // **************************************************

    // check bits: 7 hamming bits plus one overall parity bit.
    localparam int CHECK_WIDTH = 8;

    localparam int POS_WIDTH = 7;

    // positions 3..127 that are not powers of two.
    localparam int MAX_DATA_WIDTH = 120;

    typedef logic [CHECK_WIDTH-1:0] check_t;

    // the syndrome word is read two ways.
    // raw is tested for zero / one-hot, split locates a data bit.
    typedef union packed {
        logic [CHECK_WIDTH-1:0] raw;
        struct packed {
            logic                 balance;
            logic [POS_WIDTH-1:0] pos;
        } split;
    } syndrome_t;

    // **************************************************
    // coding rule
    // **************************************************

    // hamming position of data bit index.
    // data bits skip the power-of-two positions used by the check bits.
    function automatic logic [POS_WIDTH-1:0] data_position(input int unsigned index);
        int unsigned seen;

        data_position = '0;
        seen = 0;
        for (int unsigned p = 3; p < (1 << POS_WIDTH); p++) begin
            if ((p & (p - 1)) != 0) begin
                if (seen == index) begin
                    data_position = POS_WIDTH'(p);
                end
                seen++;
            end
        end
    endfunction

    // full column of data bit index.
    // top bit evens out the weight so every column is odd.
    function automatic check_t data_column(input int unsigned index);
        logic [POS_WIDTH-1:0] pos;

        pos = data_position(index);
        data_column = {~^pos, pos};
    endfunction

endpackage

`default_nettype wire

// File: source/secd_check_stage.sv
`timescale 1ns/1ps
`default_nettype none

module secd_check_stage #(
    parameter int DATA_WIDTH = 110
) (
    input  wire                        clk,
    input  wire                        arst_n,
    input  wire                        in_valid,
    input  wire [DATA_WIDTH-1:0]       data_in,
    input  wire ecc_110_pkg::check_t   parity_in,
    input  wire                        bypass,
    output logic                       s1_valid,
    output logic [DATA_WIDTH-1:0]      s1_data,
    output ecc_110_pkg::check_t        s1_check,
    output ecc_110_pkg::syndrome_t     s1_syndrome,
    output logic                       s1_bypass
);

    ecc_110_pkg::check_t    col_term [DATA_WIDTH];
    ecc_110_pkg::check_t    check_bits;
    ecc_110_pkg::syndrome_t syndrome;

    // **************************************************
    // check-bit generation
    // **************************************************

    // each data bit contributes its column when set.
    for (genvar i = 0; i < DATA_WIDTH; i++) begin : g_col
        localparam ecc_110_pkg::check_t COL = ecc_110_pkg::data_column(i);

        assign col_term[i] = data_in[i] ? COL : '0;
    end

    always_comb begin
        check_bits = '0;
        for (int i = 0; i < DATA_WIDTH; i++) begin
            check_bits = check_bits ^ col_term[i];
        end
    end

    // mismatch against what arrived with the word.
    assign syndrome.raw = check_bits ^ parity_in;

    // **************************************************
    // stage register
    // **************************************************

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            s1_valid    <= 1'b0;
            s1_bypass   <= 1'b0;
            s1_data     <= '0;
            s1_check    <= '0;
            s1_syndrome <= '0;
        end else begin
            s1_valid <= in_valid;
            if (in_valid) begin
                s1_bypass   <= bypass;
                s1_data     <= data_in;
                s1_check    <= check_bits;
                s1_syndrome <= syndrome;
            end
        end
    end

    // larger widths would run past position 127.
    initial begin
        assert (DATA_WIDTH >= 1 && DATA_WIDTH <= ecc_110_pkg::MAX_DATA_WIDTH)
        else $fatal(1, "secd_check_stage: DATA_WIDTH %0d out of range", DATA_WIDTH);
    end

endmodule

`default_nettype wire

// File: source/secd_syndrome_decode.sv
`timescale 1ns/1ps
`default_nettype none

module secd_syndrome_decode #(
    parameter int DATA_WIDTH = 110
) (
    input  wire ecc_110_pkg::syndrome_t syndrome,
    output logic [DATA_WIDTH-1:0]       mask,
    output logic                        single_err,
    output logic                        double_err
);

    logic [DATA_WIDTH-1:0] pos_hit;
    logic                  syn_zero;
    logic                  syn_one_hot;
    logic                  data_hit;

    // **************************************************
    // data bit location
    // **************************************************

    // the position field picks a candidate bit.
    // the balance bit must then agree with that column.
    for (genvar i = 0; i < DATA_WIDTH; i++) begin : g_loc
        localparam ecc_110_pkg::check_t COL = ecc_110_pkg::data_column(i);

        assign pos_hit[i] = (syndrome.split.pos == COL[ecc_110_pkg::POS_WIDTH-1:0]);
        assign mask[i]    = pos_hit[i] && (syndrome.split.balance == COL[7]);
    end

    assign data_hit = |mask;

    // **************************************************
    // error classification
    // **************************************************

    assign syn_zero = (syndrome.raw == '0);

    // a lone set bit means one of the check bits flipped.
    assign syn_one_hot = !syn_zero &&
                         ((syndrome.raw & (syndrome.raw - 8'd1)) == 8'd0);

    assign single_err = syn_one_hot || data_hit;

    // even weight or an unused position.
    assign double_err = !syn_zero && !single_err;

    // columns are distinct and odd, so at most one can match.
    // an even, nonzero syndrome is never taken for a single error.
    always_comb begin
        assert #0 (syn_zero || (^syndrome.raw) || double_err)
        else $error("secd_syndrome_decode: even syndrome not flagged as double error");
        assert #0 ($onehot0(mask))
        else $error("secd_syndrome_decode: more than one mask bit set");
    end

endmodule

`default_nettype wire

// File: source/secd_corrector.sv
`timescale 1ns/1ps
`default_nettype none

module secd_corrector #(
    parameter int DATA_WIDTH = 110
) (
    input  wire                        clk,
    input  wire                        arst_n,
    input  wire                        s1_valid,
    input  wire [DATA_WIDTH-1:0]       s1_data,
    input  wire ecc_110_pkg::check_t   s1_check,
    input  wire                        s1_bypass,
    input  wire [DATA_WIDTH-1:0]       mask,
    input  wire                        single_err,
    input  wire                        double_err,
    output logic                       out_valid,
    output logic [DATA_WIDTH-1:0]      data_out,
    output ecc_110_pkg::check_t        parity_out,
    output logic                       sbit_err,
    output logic                       dbit_err
);

    logic                  flag_en;
    logic [DATA_WIDTH-1:0] fixed_data;

    // flags only count for a live, checked word.
    assign flag_en = s1_valid && !s1_bypass;

    // mask is zero unless one data bit was located.
    assign fixed_data = s1_bypass ? s1_data : (s1_data ^ mask);

    // **************************************************
    // output register
    // **************************************************

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid  <= 1'b0;
            sbit_err   <= 1'b0;
            dbit_err   <= 1'b0;
            data_out   <= '0;
            parity_out <= '0;
        end else begin
            out_valid <= s1_valid;
            sbit_err  <= flag_en && single_err;
            dbit_err  <= flag_en && double_err;
            if (s1_valid) begin
                data_out   <= fixed_data;
                parity_out <= s1_check;
            end
        end
    end

    // a corrected data bit always comes with a single error.
    a_mask_needs_single: assert property (
        @(posedge clk) disable iff (!arst_n)
        (s1_valid && (mask != '0)) |-> (single_err && !double_err)
    ) else $error("secd_corrector: data bit corrected without a single error flag");

endmodule

`default_nettype wire

// File: source/ecc_110_cal.sv
`timescale 1ns/1ps
`default_nettype none

module ecc_110_cal #(
    parameter int DATA_WIDTH = 110
) (
    input  wire                        clk,
    input  wire                        arst_n,

    input  wire                        in_valid,
    input  wire [DATA_WIDTH-1:0]       data_in,
    input  wire ecc_110_pkg::check_t   parity_in,
    input  wire                        bypass,

    output logic                       out_valid,
    output logic [DATA_WIDTH-1:0]      data_out,
    output ecc_110_pkg::check_t        parity_out,
    output logic                       sbit_err,
    output logic                       dbit_err
);

    // **************************************************
    // stage 1 to stage 2
    // **************************************************

    logic                   s1_valid;
    logic [DATA_WIDTH-1:0]  s1_data;
    ecc_110_pkg::check_t    s1_check;
    ecc_110_pkg::syndrome_t s1_syndrome;
    logic                   s1_bypass;

    // decoder results, same cycle as stage 1 outputs.
    logic [DATA_WIDTH-1:0]  mask;
    logic                   single_err;
    logic                   double_err;

    // **************************************************
    // pipeline
    // **************************************************

    secd_check_stage #(
        .DATA_WIDTH (DATA_WIDTH)
    ) u_check_stage (
        .clk         (clk),
        .arst_n      (arst_n),
        .in_valid    (in_valid),
        .data_in     (data_in),
        .parity_in   (parity_in),
        .bypass      (bypass),
        .s1_valid    (s1_valid),
        .s1_data     (s1_data),
        .s1_check    (s1_check),
        .s1_syndrome (s1_syndrome),
        .s1_bypass   (s1_bypass)
    );

    // combinational, between the two register stages.
    secd_syndrome_decode #(
        .DATA_WIDTH (DATA_WIDTH)
    ) u_syndrome_decode (
        .syndrome   (s1_syndrome),
        .mask       (mask),
        .single_err (single_err),
        .double_err (double_err)
    );

    secd_corrector #(
        .DATA_WIDTH (DATA_WIDTH)
    ) u_corrector (
        .clk        (clk),
        .arst_n     (arst_n),
        .s1_valid   (s1_valid),
        .s1_data    (s1_data),
        .s1_check   (s1_check),
        .s1_bypass  (s1_bypass),
        .mask       (mask),
        .single_err (single_err),
        .double_err (double_err),
        .out_valid  (out_valid),
        .data_out   (data_out),
        .parity_out (parity_out),
        .sbit_err   (sbit_err),
        .dbit_err   (dbit_err)
    );

endmodule

`default_nettype wire

// File: tests/tb_ecc_model.svh
`ifndef TB_ECC_MODEL_SVH
`define TB_ECC_MODEL_SVH

// hamming position of data bit index.
// counts upward from 3 and skips every power of two.
function automatic int unsigned model_position(input int unsigned index);
    int unsigned p;
    int unsigned count;

    p = 2;
    count = 0;
    while (count <= index) begin
        p++;
        if ($countones(p) != 1) begin
            count++;
        end
    end
    return p;
endfunction

// column of data bit index; the top bit makes the weight odd.
function automatic logic [7:0] model_column(input int unsigned index);
    logic [6:0] pos;
    logic       balance;

    pos = 7'(model_position(index));
    balance = ($countones(pos) % 2) == 0;
    return {balance, pos};
endfunction

function automatic logic [7:0] model_encode(input logic [DATA_WIDTH-1:0] data);
    logic [7:0] check;

    check = '0;
    for (int i = 0; i < DATA_WIDTH; i++) begin
        if (data[i]) begin
            check = check ^ model_column(i);
        end
    end
    return check;
endfunction

// codeword is {check, data}; index counts data bits first.
function automatic logic [DATA_WIDTH+7:0] model_flip(input logic [DATA_WIDTH+7:0] codeword,
                                                     input int unsigned index);
    logic [DATA_WIDTH+7:0] flipped;

    flipped = codeword;
    flipped[index] = ~flipped[index];
    return flipped;
endfunction

// expected {dbit, sbit, data} for a word as it enters the block.
function automatic logic [DATA_WIDTH+1:0] model_expect(input logic [DATA_WIDTH-1:0] data,
                                                       input logic [7:0] parity,
                                                       input logic byp);
    logic [7:0]            syn;
    logic [DATA_WIDTH-1:0] fixed;

    syn = model_encode(data) ^ parity;
    fixed = data;
    if (byp || syn == 8'd0) begin
        return {2'b00, data};
    end
    if ($countones(syn) == 1) begin
        return {2'b01, data};
    end
    for (int i = 0; i < DATA_WIDTH; i++) begin
        if (model_column(i) == syn) begin
            fixed[i] = ~fixed[i];
            return {2'b01, fixed};
        end
    end
    return {2'b10, data};
endfunction

`endif

// File: tests/tb_ecc_110_cal.sv
`timescale 1ns/1ps
`default_nettype none

module tb_ecc_110_cal;

    localparam int DATA_WIDTH = 110;
    localparam int CODE_WIDTH = DATA_WIDTH + 8;
    // about 520 words at three cycles or less each, plus reset and gaps.
    localparam int TIMEOUT_CYCLES = 3000;

    logic                  clk;
    logic                  arst_n;
    logic                  in_valid;
    logic [DATA_WIDTH-1:0] data_in;
    logic [7:0]            parity_in;
    logic                  bypass;
    logic                  out_valid;
    logic [DATA_WIDTH-1:0] data_out;
    logic [7:0]            parity_out;
    logic                  sbit_err;
    logic                  dbit_err;

    int    seed;
    int    cycle_count;
    int    test_errors;
    int    total_errors;
    int    tests_run;
    int    tests_failed;
    string test_name;

    // expected results of the streaming test, oldest first.
    logic                  valid_q  [$];
    logic [DATA_WIDTH-1:0] data_q   [$];
    logic [7:0]            parity_q [$];
    logic [1:0]            flag_q   [$];

    `include "tb_ecc_model.svh"

    ecc_110_cal #(
        .DATA_WIDTH (DATA_WIDTH)
    ) dut (
        .clk        (clk),
        .arst_n     (arst_n),
        .in_valid   (in_valid),
        .data_in    (data_in),
        .parity_in  (parity_in),
        .bypass     (bypass),
        .out_valid  (out_valid),
        .data_out   (data_out),
        .parity_out (parity_out),
        .sbit_err   (sbit_err),
        .dbit_err   (dbit_err)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    initial begin
        wait (cycle_count >= TIMEOUT_CYCLES);
        $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Simulation failed");
        $finish;
    end

    // **************************************************
    // helpers
    // **************************************************

    task automatic start_test(input string name);
        test_name = name;
        test_errors = 0;
    endtask

    task automatic finish_test();
        tests_run++;
        total_errors += test_errors;
        if (test_errors == 0) begin
            $display("test %s: ok", test_name);
        end else begin
            $display("test %s: %0d errors", test_name, test_errors);
            tests_failed++;
        end
    endtask

    task automatic check_field(input string what, input logic [127:0] expected,
                               input logic [127:0] actual);
        assert (actual === expected)
        else begin
            $display("ERROR %s %s: expected %h, actual %h", test_name, what, expected, actual);
            test_errors++;
        end
    endtask

    function automatic logic [DATA_WIDTH-1:0] random_data();
        logic [127:0] wide;

        wide = {$random(seed), $random(seed), $random(seed), $random(seed)};
        return wide[DATA_WIDTH-1:0];
    endfunction

    function automatic int unsigned random_index(input int unsigned limit);
        int unsigned r;

        r = $random(seed);
        return r % limit;
    endfunction

    // one word in, then wait for it at the output.
    task automatic send_and_check(input logic [CODE_WIDTH-1:0] cw, input logic byp,
                                  input logic [DATA_WIDTH-1:0] exp_data,
                                  input logic exp_sbit, input logic exp_dbit);
        @(posedge clk);
        in_valid  <= 1'b1;
        data_in   <= cw[DATA_WIDTH-1:0];
        parity_in <= cw[CODE_WIDTH-1:DATA_WIDTH];
        bypass    <= byp;
        @(posedge clk);
        in_valid <= 1'b0;
        bypass   <= 1'b0;
        @(negedge clk);
        while (!out_valid) begin
            @(negedge clk);
        end
        check_field("data_out", exp_data, data_out);
        check_field("parity_out", model_encode(cw[DATA_WIDTH-1:0]), parity_out);
        check_field("sbit_err", exp_sbit, sbit_err);
        check_field("dbit_err", exp_dbit, dbit_err);
    endtask

    // **************************************************
    // directed tests
    // **************************************************

    task automatic test_reset_and_clean();
        logic [DATA_WIDTH-1:0] d;

        start_test("reset_and_clean");
        @(negedge clk);
        check_field("out_valid after reset", 0, out_valid);
        check_field("sbit_err after reset", 0, sbit_err);
        check_field("dbit_err after reset", 0, dbit_err);
        repeat (100) begin
            d = random_data();
            send_and_check({model_encode(d), d}, 1'b0, d, 1'b0, 1'b0);
        end
        finish_test();
    endtask

    task automatic test_single_data_errors();
        logic [DATA_WIDTH-1:0] d;

        start_test("single_data_errors");
        for (int i = 0; i < DATA_WIDTH; i++) begin
            d = random_data();
            send_and_check(model_flip({model_encode(d), d}, i), 1'b0, d, 1'b1, 1'b0);
        end
        finish_test();
    endtask

    task automatic test_check_bit_errors();
        logic [DATA_WIDTH-1:0] d;

        start_test("check_bit_errors");
        for (int k = 0; k < 8; k++) begin
            d = random_data();
            send_and_check(model_flip({model_encode(d), d}, DATA_WIDTH + k), 1'b0, d, 1'b1, 1'b0);
        end
        finish_test();
    endtask

    task automatic test_double_errors();
        logic [DATA_WIDTH-1:0] d;
        logic [CODE_WIDTH-1:0] cw;
        int unsigned           a;
        int unsigned           b;

        start_test("double_errors");
        repeat (100) begin
            d = random_data();
            a = random_index(CODE_WIDTH);
            b = random_index(CODE_WIDTH - 1);
            if (b >= a) begin
                b++;
            end
            cw = model_flip(model_flip({model_encode(d), d}, a), b);
            // no bit is located, so the corrupted data passes unchanged.
            send_and_check(cw, 1'b0, cw[DATA_WIDTH-1:0], 1'b0, 1'b1);
        end
        finish_test();
    endtask

    task automatic test_bypass_words();
        logic [DATA_WIDTH-1:0] d;
        logic [CODE_WIDTH-1:0] cw;

        start_test("bypass_words");
        repeat (50) begin
            d = random_data();
            cw = {model_encode(d), d} ^ {8'($random(seed)), random_data()};
            send_and_check(cw, 1'b1, cw[DATA_WIDTH-1:0], 1'b0, 1'b0);
        end
        finish_test();
    endtask

    // **************************************************
    // streaming
    // **************************************************

    // drives one cycle and checks what was driven two cycles before.
    task automatic stream_step(input logic v, input logic [CODE_WIDTH-1:0] cw, input logic byp);
        logic [DATA_WIDTH+1:0] res;
        logic                  exp_v;
        logic [DATA_WIDTH-1:0] exp_data;
        logic [7:0]            exp_parity;
        logic [1:0]            exp_flags;

        @(posedge clk);
        in_valid  <= v;
        data_in   <= cw[DATA_WIDTH-1:0];
        parity_in <= cw[CODE_WIDTH-1:DATA_WIDTH];
        bypass    <= byp;
        res = model_expect(cw[DATA_WIDTH-1:0], cw[CODE_WIDTH-1:DATA_WIDTH], byp);
        valid_q.push_back(v);
        data_q.push_back(res[DATA_WIDTH-1:0]);
        flag_q.push_back(res[DATA_WIDTH+1:DATA_WIDTH]);
        parity_q.push_back(model_encode(cw[DATA_WIDTH-1:0]));
        @(negedge clk);
        exp_v = valid_q.pop_front();
        exp_data = data_q.pop_front();
        exp_parity = parity_q.pop_front();
        exp_flags = flag_q.pop_front();
        check_field("stream out_valid", exp_v, out_valid);
        if (exp_v) begin
            check_field("stream data_out", exp_data, data_out);
            check_field("stream parity_out", exp_parity, parity_out);
            check_field("stream sbit_err", exp_flags[0], sbit_err);
            check_field("stream dbit_err", exp_flags[1], dbit_err);
        end
    endtask

    task automatic test_streaming();
        logic [DATA_WIDTH-1:0] d;
        logic [CODE_WIDTH-1:0] cw;
        logic                  byp;
        int unsigned           a;
        int unsigned           b;

        start_test("streaming");
        // the pipeline is idle on entry.
        repeat (2) begin
            valid_q.push_back(1'b0);
            data_q.push_back('0);
            parity_q.push_back('0);
            flag_q.push_back('0);
        end
        for (int n = 0; n < 150; n++) begin
            if (random_index(4) == 0) begin
                stream_step(1'b0, '0, 1'b0);
            end
            d = random_data();
            cw = {model_encode(d), d};
            byp = 1'b0;
            case (random_index(5))
                1: cw = model_flip(cw, random_index(DATA_WIDTH));
                2: cw = model_flip(cw, DATA_WIDTH + random_index(8));
                3: begin
                    a = random_index(CODE_WIDTH);
                    b = (a + 1 + random_index(CODE_WIDTH - 1)) % CODE_WIDTH;
                    cw = model_flip(model_flip(cw, a), b);
                end
                4: begin
                    cw = cw ^ {8'($random(seed)), random_data()};
                    byp = 1'b1;
                end
                default: ;
            endcase
            stream_step(1'b1, cw, byp);
        end
        repeat (2) begin
            stream_step(1'b0, '0, 1'b0);
        end
        finish_test();
    endtask

    initial begin
        seed = 32'h673d_d9f2;
        clk = 1'b0;
        arst_n = 1'b0;
        in_valid = 1'b0;
        data_in = '0;
        parity_in = '0;
        bypass = 1'b0;
        cycle_count = 0;
        test_errors = 0;
        total_errors = 0;
        tests_run = 0;
        tests_failed = 0;
        repeat (3) @(posedge clk);
        arst_n <= 1'b1;

        test_reset_and_clean();
        test_single_data_errors();
        test_check_bit_errors();
        test_double_errors();
        test_bypass_words();
        test_streaming();

        $display("tests run: %0d, tests with errors: %0d, errors: %0d",
                 tests_run, tests_failed, total_errors);
        if (total_errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: ecc_110_cal.f
+incdir+tests
source/ecc_110_pkg.sv
source/secd_check_stage.sv
source/secd_syndrome_decode.sv
source/secd_corrector.sv
source/ecc_110_cal.sv
tests/tb_ecc_110_cal.sv

// File: run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and looks for the pass line.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 -Wno-fatal \
    --top-module tb_ecc_110_cal \
    -f ecc_110_cal.f \
    || { echo "build failed"; exit 1; }

./obj_dir/Vtb_ecc_110_cal | tee /dev/stderr | grep -qx "Simulation passed" \
    && echo "run ok" \
    || { echo "run not ok"; exit 1; }
